/* rtl/dmr_recovery_pkg.sv */
// ----------------------------------------------------------------------
// DMR recovery shared constants
// ----------------------------------------------------------------------
`default_nettype none

package dmr_recovery_pkg;

  // cluster shape.
  localparam int unsigned NUM_GROUPS  = 4;                    // lock-stepped core pairs.
  localparam int unsigned GROUP_IDX_W = $clog2(NUM_GROUPS);   // faulty group index.

  // register file reload.
  localparam int unsigned RF_ADDR_W      = 5;   // 32 architectural registers.
  localparam int unsigned SWEEP_W        = 4;   // counter covers one half.
  localparam int unsigned SWEEP_LEN      = 16;  // beats per reload.
  localparam int unsigned RF_HALF_OFFSET = 16;  // port b serves the upper half.

  // pc restore window.
  localparam int unsigned PC_RESTORE_CYCLES = 2;
  localparam int unsigned PC_CNT_W          = $clog2(PC_RESTORE_CYCLES);  // cycle counter.

  // recovery routine states, in the order they are walked.
  typedef enum logic [2:0] {
    IDLE       = 3'd0,  // waiting for an error.
    RESET      = 3'd1,  // setback of the pair.
    HALT_REQ   = 3'd2,  // debug halt request.
    HALT_WAIT  = 3'd3,  // wait for halt response.
    RESTORE_PC = 3'd4,  // recovery pc readout.
    RESTORE_RF = 3'd5,  // register file reload.
    EXIT       = 3'd6   // drop held state.
  } recovery_state_e;

endpackage : dmr_recovery_pkg

`default_nettype wire

/* rtl/dmr_error_capture.sv */
// ----------------------------------------------------------------------
// DMR error capture
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dmr_error_capture (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0]  rf_err_a_i,       // rf port a checker.
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0]  rf_err_b_i,       // rf port b checker.
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0]  core_err_main_i,  // core main checker.
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0]  core_err_data_i,  // core data checker.
  input  wire logic                                   busy_i,           // routine running.
  input  wire logic                                   clear_i,          // routine exit.
  output logic                                        start_o,          // one-cycle start.
  output logic [dmr_recovery_pkg::GROUP_IDX_W-1:0]    err_idx_o         // held faulty group.
);

  logic [dmr_recovery_pkg::NUM_GROUPS-1:0]  grp_err;  // per-group or of all sources.
  logic                                     any_err;
  logic [dmr_recovery_pkg::GROUP_IDX_W-1:0] sel_idx;  // highest faulty group.
  logic                                     start_q;
  logic [dmr_recovery_pkg::GROUP_IDX_W-1:0] idx_q;

  assign grp_err = rf_err_a_i | rf_err_b_i | core_err_main_i | core_err_data_i;
  assign any_err = |grp_err;

  always_comb begin
    sel_idx = '0;
    for (int g = 0; g < dmr_recovery_pkg::NUM_GROUPS; g++) begin
      if (grp_err[g]) begin
        sel_idx = dmr_recovery_pkg::GROUP_IDX_W'(g);  // later groups override earlier.
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      idx_q   <= '0;
    end else begin
      start_q <= any_err && !busy_i;  // errors during a routine are dropped.
      if (clear_i) begin
        idx_q <= '0;
      end else if (any_err && !busy_i) begin
        idx_q <= sel_idx;
      end
    end
  end

  assign start_o   = start_q;
  assign err_idx_o = idx_q;

endmodule : dmr_error_capture

`default_nettype wire

/* rtl/dmr_recovery_fsm.sv */
// ----------------------------------------------------------------------
// DMR recovery routine sequencer
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dmr_recovery_fsm (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic                                    start_i,         // from error capture.
  input  wire logic [dmr_recovery_pkg::GROUP_IDX_W-1:0]  err_idx_i,       // target group.
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0]   debug_rsp_i,     // halt acknowledge.
  input  wire logic                                    sweep_last_i,    // last reload address.
  output logic                                         busy_o,          // freezes capture.
  output logic                                         clear_o,         // exit cleanup.
  output logic                                         sweep_en_o,      // reload in progress.
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      setback_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      debug_req_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      pc_read_en_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      debug_resume_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      recover_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      instr_lock_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      pc_write_en_o
);

  dmr_recovery_pkg::recovery_state_e state_q, state_d;

  logic [dmr_recovery_pkg::PC_CNT_W-1:0]   pc_cnt_q, pc_cnt_d;    // pc restore cycles.
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] lock_q, lock_d;        // fetch lock.
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] recover_q, recover_d;  // rf reload flag.
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] pcwe_q, pcwe_d;        // recovery pc sampling.

  always_comb begin
    state_d        = state_q;
    pc_cnt_d       = pc_cnt_q;
    lock_d         = lock_q;
    recover_d      = recover_q;
    pcwe_d         = pcwe_q;
    clear_o        = 1'b0;
    sweep_en_o     = 1'b0;
    setback_o      = '0;
    debug_req_o    = '0;
    pc_read_en_o   = '0;
    debug_resume_o = '0;
    unique case (state_q)
      dmr_recovery_pkg::IDLE: begin
        if (start_i) begin
          state_d = dmr_recovery_pkg::RESET;
        end
      end
      dmr_recovery_pkg::RESET: begin
        setback_o[err_idx_i] = 1'b1;  // reset the pair.
        lock_d[err_idx_i]    = 1'b1;  // no fetches while halted.
        pcwe_d[err_idx_i]    = 1'b0;  // freeze the recovery pc.
        state_d              = dmr_recovery_pkg::HALT_REQ;
      end
      dmr_recovery_pkg::HALT_REQ: begin
        debug_req_o[err_idx_i] = 1'b1;
        state_d                = dmr_recovery_pkg::HALT_WAIT;
      end
      dmr_recovery_pkg::HALT_WAIT: begin
        if (debug_rsp_i[err_idx_i]) begin  // pair is halted.
          state_d = dmr_recovery_pkg::RESTORE_PC;
        end
      end
      dmr_recovery_pkg::RESTORE_PC: begin
        pc_read_en_o[err_idx_i] = 1'b1;
        if (pc_cnt_q == dmr_recovery_pkg::PC_CNT_W'(dmr_recovery_pkg::PC_RESTORE_CYCLES - 1)) begin
          pc_cnt_d = '0;
          state_d  = dmr_recovery_pkg::RESTORE_RF;
        end else begin
          pc_cnt_d = pc_cnt_q + dmr_recovery_pkg::PC_CNT_W'(1);
        end
      end
      dmr_recovery_pkg::RESTORE_RF: begin
        sweep_en_o           = 1'b1;
        recover_d[err_idx_i] = 1'b1;  // registered, so it lines up with the write beats.
        if (sweep_last_i) begin
          lock_d[err_idx_i]         = 1'b0;
          debug_resume_o[err_idx_i] = 1'b1;
          state_d                   = dmr_recovery_pkg::EXIT;
        end
      end
      dmr_recovery_pkg::EXIT: begin
        clear_o   = 1'b1;  // index and address counter back to zero.
        pc_cnt_d  = '0;
        lock_d    = '0;
        recover_d = '0;
        pcwe_d    = '1;    // recovery pc samples again.
        state_d   = dmr_recovery_pkg::IDLE;
      end
      default: begin
        state_d = dmr_recovery_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= dmr_recovery_pkg::IDLE;
      pc_cnt_q  <= '0;
      lock_q    <= '0;
      recover_q <= '0;
      pcwe_q    <= '1;  // pc sampling enabled out of reset.
    end else begin
      state_q   <= state_d;
      pc_cnt_q  <= pc_cnt_d;
      lock_q    <= lock_d;
      recover_q <= recover_d;
      pcwe_q    <= pcwe_d;
    end
  end

  // capture must also hold while the start pulse is still in flight.
  assign busy_o        = (state_q != dmr_recovery_pkg::IDLE) || start_i;
  assign instr_lock_o  = lock_q;
  assign recover_o     = recover_q;
  assign pc_write_en_o = pcwe_q;

endmodule : dmr_recovery_fsm

`default_nettype wire

/* rtl/dmr_rf_addr_gen.sv */
// ----------------------------------------------------------------------
// DMR reload address counter
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dmr_rf_addr_gen (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire logic                                 clear_i,   // back to zero.
  input  wire logic                                 enable_i,  // count this cycle.
  output logic [dmr_recovery_pkg::SWEEP_W-1:0]      addr_o,    // current reload step.
  output logic                                      last_o     // final step of the sweep.
);

  logic [dmr_recovery_pkg::SWEEP_W-1:0] cnt_q;
  logic                                 at_end;  // count sits on the last step.

  assign at_end = (cnt_q == dmr_recovery_pkg::SWEEP_W'(dmr_recovery_pkg::SWEEP_LEN - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (enable_i) begin
      if (at_end) begin
        cnt_q <= '0;  // wrap for the next routine.
      end else begin
        cnt_q <= cnt_q + dmr_recovery_pkg::SWEEP_W'(1);
      end
    end
  end

  assign addr_o = cnt_q;
  assign last_o = enable_i && at_end;  // only meaningful while sweeping.

endmodule : dmr_rf_addr_gen

`default_nettype wire

/* rtl/dmr_rf_restore_port.sv */
// ----------------------------------------------------------------------
// DMR recovery write port stage
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dmr_rf_restore_port (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic                                    sweep_en_i,    // reload beat valid.
  input  wire logic [dmr_recovery_pkg::SWEEP_W-1:0]      sweep_addr_i,  // reload step.
  input  wire logic [dmr_recovery_pkg::GROUP_IDX_W-1:0]  err_idx_i,     // target group.
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      rf_we_a_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]      rf_we_b_o,
  output logic [dmr_recovery_pkg::RF_ADDR_W-1:0]       rf_waddr_a_o,  // lower half.
  output logic [dmr_recovery_pkg::RF_ADDR_W-1:0]       rf_waddr_b_o   // upper half.
);

  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] we_d, we_a_q, we_b_q;
  logic [dmr_recovery_pkg::RF_ADDR_W-1:0]  waddr_a_d, waddr_b_d;
  logic [dmr_recovery_pkg::RF_ADDR_W-1:0]  waddr_a_q, waddr_b_q;

  always_comb begin
    for (int g = 0; g < dmr_recovery_pkg::NUM_GROUPS; g++) begin
      we_d[g] = sweep_en_i && (err_idx_i == dmr_recovery_pkg::GROUP_IDX_W'(g));  // one-hot.
    end
  end

  // buses idle at zero outside the sweep.
  assign waddr_a_d = sweep_en_i ? dmr_recovery_pkg::RF_ADDR_W'(sweep_addr_i) : '0;
  assign waddr_b_d = sweep_en_i ? dmr_recovery_pkg::RF_ADDR_W'(sweep_addr_i)
                                  + dmr_recovery_pkg::RF_ADDR_W'(dmr_recovery_pkg::RF_HALF_OFFSET)
                                : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_a_q    <= '0;
      we_b_q    <= '0;
      waddr_a_q <= '0;
      waddr_b_q <= '0;
    end else begin
      we_a_q    <= we_d;  // both ports write every beat.
      we_b_q    <= we_d;
      waddr_a_q <= waddr_a_d;
      waddr_b_q <= waddr_b_d;
    end
  end

  assign rf_we_a_o    = we_a_q;
  assign rf_we_b_o    = we_b_q;
  assign rf_waddr_a_o = waddr_a_q;
  assign rf_waddr_b_o = waddr_b_q;

endmodule : dmr_rf_restore_port

`default_nettype wire

/* rtl/dmr_recovery_ctrl.sv */
// ----------------------------------------------------------------------
// DMR recovery controller top
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dmr_recovery_ctrl (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] rf_err_a_i,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] rf_err_b_i,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] core_err_main_i,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] core_err_data_i,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] debug_rsp_i,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    setback_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    instr_lock_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    pc_read_en_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    pc_write_en_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    debug_req_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    debug_resume_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    recover_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    rf_we_a_o,
  output logic [dmr_recovery_pkg::NUM_GROUPS-1:0]    rf_we_b_o,
  output logic [dmr_recovery_pkg::RF_ADDR_W-1:0]     rf_waddr_a_o,
  output logic [dmr_recovery_pkg::RF_ADDR_W-1:0]     rf_waddr_b_o
);

  logic                                     start;       // capture to fsm.
  logic [dmr_recovery_pkg::GROUP_IDX_W-1:0] err_idx;     // held target group.
  logic                                     busy;        // fsm to capture.
  logic                                     clear;       // exit cleanup.
  logic                                     sweep_en;    // reload active.
  logic                                     sweep_last;  // final reload step.
  logic [dmr_recovery_pkg::SWEEP_W-1:0]     sweep_addr;

  dmr_error_capture u_capture (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rf_err_a_i      (rf_err_a_i),
    .rf_err_b_i      (rf_err_b_i),
    .core_err_main_i (core_err_main_i),
    .core_err_data_i (core_err_data_i),
    .busy_i          (busy),
    .clear_i         (clear),
    .start_o         (start),
    .err_idx_o       (err_idx)
  );

  dmr_recovery_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start),
    .err_idx_i      (err_idx),
    .debug_rsp_i    (debug_rsp_i),
    .sweep_last_i   (sweep_last),
    .busy_o         (busy),
    .clear_o        (clear),
    .sweep_en_o     (sweep_en),
    .setback_o      (setback_o),
    .debug_req_o    (debug_req_o),
    .pc_read_en_o   (pc_read_en_o),
    .debug_resume_o (debug_resume_o),
    .recover_o      (recover_o),
    .instr_lock_o   (instr_lock_o),
    .pc_write_en_o  (pc_write_en_o)
  );

  dmr_rf_addr_gen u_addr_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear),
    .enable_i (sweep_en),
    .addr_o   (sweep_addr),
    .last_o   (sweep_last)
  );

  dmr_rf_restore_port u_restore_port (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sweep_en_i   (sweep_en),
    .sweep_addr_i (sweep_addr),
    .err_idx_i    (err_idx),
    .rf_we_a_o    (rf_we_a_o),
    .rf_we_b_o    (rf_we_b_o),
    .rf_waddr_a_o (rf_waddr_a_o),
    .rf_waddr_b_o (rf_waddr_b_o)
  );

endmodule : dmr_recovery_ctrl

`default_nettype wire

/* tb/dmr_recovery_checker.sv */
// ----------------------------------------------------------------------
// DMR recovery reference checker
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module dmr_recovery_checker (
  input  wire logic                                    clk_i, rst_ni,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] rf_err_a_i, rf_err_b_i, debug_rsp_i,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] core_err_main_i, core_err_data_i,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] setback_o, debug_req_o, pc_read_en_o,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] debug_resume_o, recover_o, instr_lock_o,
  input  wire logic [dmr_recovery_pkg::NUM_GROUPS-1:0] pc_write_en_o, rf_we_a_o, rf_we_b_o,
  input  wire logic [dmr_recovery_pkg::RF_ADDR_W-1:0]  rf_waddr_a_o, rf_waddr_b_o,
  input  wire dmr_recovery_pkg::recovery_state_e       state_i,  // dut state, named in errors.
  output int                                           pass_cnt_o, fail_cnt_o, mism_cnt_o
);

  // model phases, one per cycle of the routine.
  typedef enum int {M_IDLE, M_START, M_RESET, M_HREQ, M_HWAIT, M_PC, M_RF, M_EXIT} phase_e;

  phase_e                                  phase = M_IDLE;
  int                                      tgt, pc_cnt, beat, bad, routine;
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] hot, errs, lock_exp, pcwe_exp;
  logic                                    beat_on;  // write beat expected this cycle.
  logic [dmr_recovery_pkg::RF_ADDR_W-1:0]  wa;       // expected port a address.

  task automatic compare_signal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %0h got %0h (dut in %s)", $time, name, exp, act,
               state_i.name());
      bad++;
      mism_cnt_o++;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      phase      = M_IDLE;
      tgt        = 0;
      bad        = 0;
      routine    = 0;
      pass_cnt_o = 0;
      fail_cnt_o = 0;
      mism_cnt_o = 0;
    end else begin
      hot      = '0;
      hot[tgt] = 1'b1;  // target group as one-hot.
      errs     = rf_err_a_i | rf_err_b_i | core_err_main_i | core_err_data_i;
      beat_on  = (phase == M_RF && beat > 0) || phase == M_EXIT;  // writes lag the count.
      wa       = beat_on ? dmr_recovery_pkg::RF_ADDR_W'(beat - 1) : '0;
      lock_exp = (phase >= M_HREQ && phase <= M_RF) ? hot : '0;
      pcwe_exp = ~((phase >= M_HREQ) ? hot : '0);  // other groups keep sampling.
      compare_signal("setback_o", (phase == M_RESET) ? hot : '0, setback_o);
      compare_signal("debug_req_o", (phase == M_HREQ) ? hot : '0, debug_req_o);
      compare_signal("pc_read_en_o", (phase == M_PC) ? hot : '0, pc_read_en_o);
      compare_signal("debug_resume_o",
                     (phase == M_RF && beat == dmr_recovery_pkg::SWEEP_LEN - 1) ? hot : '0,
                     debug_resume_o);
      compare_signal("recover_o", beat_on ? hot : '0, recover_o);
      compare_signal("rf_we_a_o", beat_on ? hot : '0, rf_we_a_o);
      compare_signal("rf_we_b_o", beat_on ? hot : '0, rf_we_b_o);
      compare_signal("rf_waddr_a_o", wa, rf_waddr_a_o);
      compare_signal("rf_waddr_b_o", beat_on ? wa + dmr_recovery_pkg::RF_HALF_OFFSET : 0,
                     rf_waddr_b_o);
      compare_signal("instr_lock_o", lock_exp, instr_lock_o);
      compare_signal("pc_write_en_o", pcwe_exp, pc_write_en_o);
      case (phase)
        M_IDLE: begin
          for (int g = 0; g < dmr_recovery_pkg::NUM_GROUPS; g++) begin
            if (errs[g]) begin
              tgt = g;  // highest faulty group wins.
            end
          end
          phase = (|errs) ? M_START : M_IDLE;
        end
        M_START: begin
          pc_cnt = 0;
          beat   = 0;
          phase  = M_RESET;
        end
        M_RESET: phase = M_HREQ;
        M_HREQ:  phase = M_HWAIT;
        M_HWAIT: phase = debug_rsp_i[tgt] ? M_PC : M_HWAIT;  // variable halt latency.
        M_PC: begin
          pc_cnt++;
          phase = (pc_cnt == dmr_recovery_pkg::PC_RESTORE_CYCLES) ? M_RF : M_PC;
        end
        M_RF: begin
          phase = (beat == dmr_recovery_pkg::SWEEP_LEN - 1) ? M_EXIT : M_RF;
          beat++;
        end
        default: begin  // exit cycle, routine complete.
          routine++;
          if (bad == 0) begin
            pass_cnt_o++;
            $display("routine %0d on group %0d: ok", routine, tgt);
          end else begin
            fail_cnt_o++;
            $display("routine %0d on group %0d: %0d mismatches", routine, tgt, bad);
          end
          bad   = 0;
          phase = M_IDLE;
        end
      endcase
    end
  end

endmodule : dmr_recovery_checker

`default_nettype wire

/* tb/tb_dmr_recovery_ctrl.sv */
// ----------------------------------------------------------------------
// DMR recovery controller testbench
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_dmr_recovery_ctrl;

  logic                                    clk_i, rst_ni;
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] rf_err_a_i, rf_err_b_i, debug_rsp_i;
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] core_err_main_i, core_err_data_i;
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] setback_o, debug_req_o, pc_read_en_o;
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] debug_resume_o, recover_o, instr_lock_o;
  logic [dmr_recovery_pkg::NUM_GROUPS-1:0] pc_write_en_o, rf_we_a_o, rf_we_b_o;
  logic [dmr_recovery_pkg::RF_ADDR_W-1:0]  rf_waddr_a_o, rf_waddr_b_o;
  dmr_recovery_pkg::recovery_state_e       fsm_state;
  int                                      pass_cnt_o, fail_cnt_o, mism_cnt_o;
  int                                      cycles = 0;
  int                                      routines = 20;  // recovery routines to run.

  dmr_recovery_ctrl dut (.*);

  assign fsm_state = dut.u_fsm.state_q;  // only used in checker messages.

  dmr_recovery_checker u_checker (.state_i(fsm_state), .*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns period.
  end

  // longest routine plus halt latency, per routine, and some slack.
  initial begin : watchdog
    while (cycles < routines * (dmr_recovery_pkg::SWEEP_LEN + 20 + 7) + 200) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles with %0d routines checked", cycles,
             pass_cnt_o + fail_cnt_o);
    $display("Simulation FAILED");
    $finish;
  end

  // halted pair answers a halt request 0 to 7 cycles into the wait.
  initial begin : debug_responder
    logic [dmr_recovery_pkg::NUM_GROUPS-1:0] req;
    forever begin
      @(negedge clk_i);
      req = debug_req_o;
      if (req != '0) begin
        repeat ($urandom_range(1, 8)) @(negedge clk_i);
        debug_rsp_i = req;
        @(negedge clk_i);
        debug_rsp_i = '0;
      end
    end
  end

  // one-cycle error on a random source, 1 to 4 random groups.
  task automatic pulse_error();
    logic [dmr_recovery_pkg::NUM_GROUPS-1:0] mask;
    mask = dmr_recovery_pkg::NUM_GROUPS'($urandom_range(1, 15));
    {core_err_data_i, core_err_main_i, rf_err_b_i, rf_err_a_i} =
      (4 * dmr_recovery_pkg::NUM_GROUPS)'(mask)
        << (dmr_recovery_pkg::NUM_GROUPS * $urandom_range(0, 3));
    @(negedge clk_i);
    {core_err_data_i, core_err_main_i, rf_err_b_i, rf_err_a_i} = '0;
  endtask

  initial begin : stimulus
    void'($urandom(81));  // single seed for the run.
    rst_ni      = 1'b0;
    debug_rsp_i = '0;
    {core_err_data_i, core_err_main_i, rf_err_b_i, rf_err_a_i} = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int r = 0; r < routines; r++) begin
      repeat ($urandom_range(0, 3)) @(negedge clk_i);  // idle gap.
      pulse_error();  // starts the routine.
      repeat ($urandom_range(1, 3)) begin
        repeat ($urandom_range(0, 5)) @(negedge clk_i);  // zero hits the start cycle.
        pulse_error();  // lands while busy, must be ignored.
      end
      while (debug_resume_o == '0) @(negedge clk_i);
      repeat (2) @(negedge clk_i);  // exit cycle, then idle.
    end
    repeat (3) @(negedge clk_i);
    $display("routines: %0d passed, %0d failed, %0d mismatches", pass_cnt_o, fail_cnt_o,
             mism_cnt_o);
    if (fail_cnt_o == 0 && mism_cnt_o == 0 && pass_cnt_o == routines) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_dmr_recovery_ctrl

`default_nettype wire

/* dmr_recovery_ctrl.f */
rtl/dmr_recovery_pkg.sv
rtl/dmr_error_capture.sv
rtl/dmr_recovery_fsm.sv
rtl/dmr_rf_addr_gen.sv
rtl/dmr_rf_restore_port.sv
rtl/dmr_recovery_ctrl.sv
tb/dmr_recovery_checker.sv
tb/tb_dmr_recovery_ctrl.sv

/* Bender.yml */
package:
  name: dmr_recovery_ctrl

sources:
  - rtl/dmr_recovery_pkg.sv
  - rtl/dmr_error_capture.sv
  - rtl/dmr_recovery_fsm.sv
  - rtl/dmr_rf_addr_gen.sv
  - rtl/dmr_rf_restore_port.sv
  - rtl/dmr_recovery_ctrl.sv
  - target: test
    files:
      - tb/dmr_recovery_checker.sv
      - tb/tb_dmr_recovery_ctrl.sv
